/* fetch_consts.svh */
// Sizing constants for the fetch front end
// Memory depth and index width must agree (depth = 2**index width)
// Reset PC must be word aligned and inside the instruction memory
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// First PC fetched after reset release
`define FETCH_RESET_PC 32'h0000_0000

// Instruction memory size in 32-bit words
`define IMEM_DEPTH 256

// Word index width into the instruction memory
`define IMEM_IDX_W 8

`endif

/* rv_isa_pkg.sv */
// RV32 instruction encodings used by the fetch predecoder
// Only the J-type field layout is modelled; other formats read through raw
package rv_isa_pkg;

    // Base opcode map, bits [6:0]
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,
        OP_OP_IMM   = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_STORE    = 7'b0100011,
        OP_OP       = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111,
        OP_SYSTEM   = 7'b1110011
    } opcode_e;

    // J-type layout, MSB first
    // Immediate bits are scattered as in the ISA spec
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_s;

    // One fetched word, seen either raw or as J-type fields
    typedef union packed {
        logic [31:0] raw;
        j_type_s     j;
    } instr_u;

endpackage

/* fetch_pkg.sv */
// Types passed between the fetch stages and out of the front end
// Depends on rv_isa_pkg, compile that first
package fetch_pkg;

    // Byte address, low two bits always zero in this front end
    typedef logic [31:0] pc_t;

    // Fetch 1 to fetch 2 payload
    // Valid travels beside it as a separate level
    typedef struct packed {
        pc_t pc;
    } f1_to_f2_s;

    // Request into the instruction memory
    typedef struct packed {
        logic en;
        pc_t  addr;
    } imem_req_s;

    // Fetch 2 output towards decode
    typedef struct packed {
        pc_t                pc;
        rv_isa_pkg::instr_u instr;
        // Set when instr is a JAL, already acted on by the front end
        logic               is_jal;
    } f2_out_s;

endpackage

/* fetch1_pc_gen.sv */
// Fetch stage 1: PC register and fetch address generation
// Memory address register is sampled every cycle, so the address sent here
// is next_pc while moving and pc_ff while stalled or in post-reset init
// Stall and flush must never be high together
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch1_pc_gen (
    input  logic                 clk,
    input  logic                 rst_n,

    // PC load from the hazard controller
    input  logic                 pc_load_en,
    input  fetch_pkg::pc_t       pc_load_val,

    // Stage controls
    input  logic                 f1_stall,
    input  logic                 f1_flush,

    // Memory request and fetch 2 side
    output fetch_pkg::imem_req_s imem_req,
    output logic                 f1_valid,
    output fetch_pkg::f1_to_f2_s f1_to_f2
);

    logic           init_q;
    fetch_pkg::pc_t pc_ff;
    fetch_pkg::pc_t next_pc;
    fetch_pkg::pc_t fetch_addr;
    logic           pc_move;

    // Init lasts one unstalled cycle after reset
    // While set, the reset PC goes out as the first address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_q <= 1'b1;
        end else if (!f1_stall) begin
            init_q <= 1'b0;
        end
    end

    // Load wins over sequential step
    assign next_pc = pc_load_en ? pc_load_val : pc_ff + 32'd4;

    // A load during init still moves the PC, init only blocks the step
    assign pc_move = !f1_stall && (!init_q || pc_load_en);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_ff <= `FETCH_RESET_PC;
        end else if (pc_move) begin
            pc_ff <= next_pc;
        end
    end

    // Delayed fetch address has to equal pc_ff in the next cycle
    assign fetch_addr = pc_move ? next_pc : pc_ff;

    // Flushed or stalled cycles do not start a read
    assign imem_req.en   = !f1_flush && !f1_stall;
    assign imem_req.addr = fetch_addr;

    // Nothing valid leaves during init
    assign f1_valid    = !init_q && !f1_flush && !f1_stall;
    assign f1_to_f2.pc = pc_ff;

endmodule

/* imem_sync_ram.sv */
// Word-addressed instruction memory for the fetch front end
// Address index is sampled every cycle; the read is registered when en is high
// so rdata follows one clock after an enabled cycle and holds otherwise
// Upper address bits above the index are ignored, no out-of-range check
// Write port is meant for loading while the core is held in reset
`timescale 1ns/1ns
`include "fetch_consts.svh"

module imem_sync_ram (
    input  logic                    clk,
    input  fetch_pkg::imem_req_s    imem_req,

    // Loader port
    input  logic                    wr_en,
    input  logic [`IMEM_IDX_W-1:0]  wr_idx,
    input  rv_isa_pkg::instr_u      wr_data,

    output rv_isa_pkg::instr_u      rdata
);

    rv_isa_pkg::instr_u         mem [`IMEM_DEPTH];
    logic [`IMEM_IDX_W-1:0]     rd_idx_q;

    // Loader writes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // Address flop has no enable, byte address to word index
    always_ff @(posedge clk) begin
        rd_idx_q <= imem_req.addr[`IMEM_IDX_W+1:2];
    end

    // Read data register, held on stalled and flushed cycles
    always_ff @(posedge clk) begin
        if (imem_req.en) begin
            rdata <= mem[rd_idx_q];
        end
    end

endmodule

/* fetch2_predecode.sv */
// Fetch stage 2: aligns the returned word with its PC and predecodes JAL
// rdata must belong to the PC registered here in every unstalled cycle
// Returned word is captured when stall rises and replayed until it falls
// jal_redirect is raw; the hazard controller decides when it acts
`timescale 1ns/1ns

module fetch2_predecode (
    input  logic                 clk,
    input  logic                 rst_n,

    // From fetch 1 and the memory
    input  logic                 f1_valid,
    input  fetch_pkg::f1_to_f2_s f1_to_f2,
    input  rv_isa_pkg::instr_u   rdata,

    // Stage controls
    input  logic                 f2_stall,
    input  logic                 f2_flush,

    // Towards decode
    output logic                 out_valid,
    output fetch_pkg::f2_out_s   out,

    // JAL redirect request
    output logic                 jal_redirect,
    output fetch_pkg::pc_t       jal_target
);

    logic               valid_q;
    fetch_pkg::pc_t     pc_q;
    rv_isa_pkg::instr_u hold_q;
    logic               hold_active_q;
    rv_isa_pkg::instr_u instr;
    logic [31:0]        j_imm;

    // Valid bit, flush kills whatever is in the stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (f2_flush) begin
            valid_q <= 1'b0;
        end else if (!f2_stall) begin
            valid_q <= f1_valid;
        end
    end

    // PC follows the valid bit
    always_ff @(posedge clk) begin
        if (!f2_stall) begin
            pc_q <= f1_to_f2.pc;
        end
    end

    // Hold flag, set on the first stalled cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_active_q <= 1'b0;
        end else begin
            hold_active_q <= f2_stall;
        end
    end

    // Only the word present when stall rises is kept
    always_ff @(posedge clk) begin
        if (f2_stall && !hold_active_q) begin
            hold_q <= rdata;
        end
    end

    assign instr = hold_active_q ? hold_q : rdata;

    // J immediate, sign extended, bit 0 always zero
    assign j_imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    assign out_valid  = valid_q;
    assign out.pc     = pc_q;
    assign out.instr  = instr;
    assign out.is_jal = (instr.j.opcode == rv_isa_pkg::OP_JAL);

    assign jal_redirect = valid_q && out.is_jal;
    assign jal_target   = pc_q + j_imm;

endmodule

/* fetch_hazard_ctrl.sv */
// Hazard controller for the two fetch stages, purely combinational
// External redirect beats a JAL redirect and overrides a downstream stall
// A JAL only redirects on the cycle it is accepted downstream
`timescale 1ns/1ns

module fetch_hazard_ctrl (
    input  logic           out_stall,
    input  logic           redirect_en,
    input  fetch_pkg::pc_t redirect_pc,
    input  logic           jal_redirect,
    input  fetch_pkg::pc_t jal_target,

    output logic           f1_stall,
    output logic           f1_flush,
    output logic           f2_stall,
    output logic           f2_flush,
    output logic           pc_load_en,
    output fetch_pkg::pc_t pc_load_val
);

    logic jal_take;

    // JAL held under back-pressure waits
    assign jal_take = jal_redirect && !out_stall;

    always_comb begin
        f1_stall    = out_stall;
        f2_stall    = out_stall;
        f1_flush    = 1'b0;
        f2_flush    = 1'b0;
        pc_load_en  = 1'b0;
        pc_load_val = '0;

        if (redirect_en) begin
            // Everything in flight is wrong path, stall dropped
            f1_stall    = 1'b0;
            f2_stall    = 1'b0;
            f1_flush    = 1'b1;
            f2_flush    = 1'b1;
            pc_load_en  = 1'b1;
            pc_load_val = redirect_pc;
        end else if (jal_take) begin
            // JAL itself leaves fetch 2, only fetch 1 is wrong path
            f1_flush    = 1'b1;
            pc_load_en  = 1'b1;
            pc_load_val = jal_target;
        end
    end

endmodule

/* fetch_frontend_top.sv */
// Fetch front end: PC generation, instruction memory, predecode, hazards
// First instruction leaves 2 cycles after the first unstalled cycle
// Memory should be loaded through the write port while rst_n is low
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_frontend_top (
    input  logic                   clk,
    input  logic                   rst_n,

    // Downstream back-pressure and redirect
    input  logic                   out_stall,
    input  logic                   redirect_en,
    input  fetch_pkg::pc_t         redirect_pc,

    // Memory loader
    input  logic                   wr_en,
    input  logic [`IMEM_IDX_W-1:0] wr_idx,
    input  rv_isa_pkg::instr_u     wr_data,

    output logic                   out_valid,
    output fetch_pkg::f2_out_s     out
);

    fetch_pkg::imem_req_s imem_req;
    rv_isa_pkg::instr_u   rdata;
    logic                 f1_valid;
    fetch_pkg::f1_to_f2_s f1_to_f2;
    logic                 f1_stall;
    logic                 f1_flush;
    logic                 f2_stall;
    logic                 f2_flush;
    logic                 pc_load_en;
    fetch_pkg::pc_t       pc_load_val;
    logic                 jal_redirect;
    fetch_pkg::pc_t       jal_target;

    fetch1_pc_gen u_fetch1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_load_en  (pc_load_en),
        .pc_load_val (pc_load_val),
        .f1_stall    (f1_stall),
        .f1_flush    (f1_flush),
        .imem_req    (imem_req),
        .f1_valid    (f1_valid),
        .f1_to_f2    (f1_to_f2)
    );

    imem_sync_ram u_imem (
        .clk      (clk),
        .imem_req (imem_req),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .rdata    (rdata)
    );

    fetch2_predecode u_fetch2 (
        .clk          (clk),
        .rst_n        (rst_n),
        .f1_valid     (f1_valid),
        .f1_to_f2     (f1_to_f2),
        .rdata        (rdata),
        .f2_stall     (f2_stall),
        .f2_flush     (f2_flush),
        .out_valid    (out_valid),
        .out          (out),
        .jal_redirect (jal_redirect),
        .jal_target   (jal_target)
    );

    fetch_hazard_ctrl u_hazard (
        .out_stall    (out_stall),
        .redirect_en  (redirect_en),
        .redirect_pc  (redirect_pc),
        .jal_redirect (jal_redirect),
        .jal_target   (jal_target),
        .f1_stall     (f1_stall),
        .f1_flush     (f1_flush),
        .f2_stall     (f2_stall),
        .f2_flush     (f2_flush),
        .pc_load_en   (pc_load_en),
        .pc_load_val  (pc_load_val)
    );

endmodule

/* tb_fetch_frontend.sv */
// Self-checking testbench for the fetch front end, random program from xorshift (seed 61)
// About one word in eight is a JAL whose target stays inside the instruction memory
// Reset stays low while the program is loaded, then for 16 more cycles
// Inputs change on the falling edge and outputs are sampled there too
`timescale 1ns/1ns
`include "fetch_consts.svh"

module tb_fetch_frontend;

    localparam int RESET_CYCLES = 16;
    localparam int T1_CYCLES = 8;
    localparam int T2_CYCLES = 60;
    localparam int T3_CYCLES = 200;
    localparam int T4_CYCLES = 400;
    localparam int T5_CYCLES = 400;
    localparam int TEST_CYCLES = `IMEM_DEPTH + RESET_CYCLES + T1_CYCLES + T2_CYCLES
                                 + T3_CYCLES + T4_CYCLES + T5_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 100;
    localparam logic [6:0] JAL_OPCODE = 7'b1101111;

    logic                   clk;
    logic                   rst_n;
    logic                   out_stall;
    logic                   redirect_en;
    fetch_pkg::pc_t         redirect_pc;
    logic                   wr_en;
    logic [`IMEM_IDX_W-1:0] wr_idx;
    rv_isa_pkg::instr_u     wr_data;
    logic                   out_valid;
    fetch_pkg::f2_out_s     out;

    // Reference model state
    logic [31:0]        mirror [`IMEM_DEPTH];
    logic [31:0]        rng_state;
    fetch_pkg::pc_t     exp_pc;
    logic               hold_expected;
    logic               prev_valid;
    fetch_pkg::f2_out_s prev_out;
    logic               last_accept;
    fetch_pkg::f2_out_s last_out;
    logic               redirect_pending;
    int errors;
    int errors_mark;
    int checks;
    int accepted;
    int jal_count;
    int redirect_count;
    int cycle_cnt;
    int first;
    int mark;

    fetch_frontend_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog, ends the run if the tests overrun
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt <= TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // xorshift32, shifts 13 17 5
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // J-type immediate as laid out by the ISA, sign extended
    function automatic fetch_pkg::pc_t jal_offset(input logic [31:0] w);
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input fetch_pkg::pc_t got,
                            input fetch_pkg::pc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_instr(input string name, input rv_isa_pkg::instr_u got,
                               input rv_isa_pkg::instr_u exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got.raw, exp.raw);
        end
    endtask

    task automatic check_out(input string name, input fetch_pkg::f2_out_s got,
                             input fetch_pkg::f2_out_s exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Random words with JAL opcode avoided, then some JALs of +-16 words
    task automatic load_program();
        logic [31:0] r;
        logic [31:0] word;
        int off;
        int i;
        for (i = 0; i < `IMEM_DEPTH; i++) begin
            r = next_random();
            word = next_random();
            if (r[2:0] == 3'd0) begin
                off = int'(r[7:3]) - 16;
                if (off == 0) begin
                    off = 1;
                end
                if (i + off < 0 || i + off >= `IMEM_DEPTH) begin
                    off = -off;
                end
                r = 32'(off * 4);
                word = {r[20], r[10:1], r[11], r[19:12], word[11:7], JAL_OPCODE};
            end else if (word[6:0] == JAL_OPCODE) begin
                word[3] = 1'b0;
            end
            mirror[i] = word;
            @(negedge clk);
            wr_en = 1'b1;
            wr_idx = i[`IMEM_IDX_W-1:0];
            wr_data.raw = word;
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // One cycle: check what the DUT shows, drive inputs, advance the model
    task automatic drive_cycle(input logic stall, input logic redir, input fetch_pkg::pc_t rpc);
        fetch_pkg::f2_out_s exp_out;
        @(negedge clk);
        if (hold_expected) begin
            check_flag("out_valid", out_valid, prev_valid);
            check_out("out under stall", out, prev_out);
        end
        out_stall = stall;
        redirect_en = redir;
        redirect_pc = rpc;
        last_accept = out_valid && !stall;
        last_out = out;
        if (last_accept) begin
            exp_out.pc = exp_pc;
            exp_out.instr.raw = mirror[exp_pc[`IMEM_IDX_W+1:2]];
            exp_out.is_jal = (exp_out.instr.raw[6:0] == JAL_OPCODE);
            check_out("out", out, exp_out);
            accepted++;
            // First delivery after a redirect lands on its target
            if (redirect_pending) begin
                redirect_count++;
                redirect_pending = 1'b0;
            end
            if (exp_out.is_jal) begin
                jal_count++;
                exp_pc = exp_pc + jal_offset(exp_out.instr.raw);
            end else begin
                exp_pc = exp_pc + 32'd4;
            end
        end
        // A redirect beats a JAL taken in the same cycle
        if (redir) begin
            exp_pc = rpc;
            redirect_pending = 1'b1;
        end
        hold_expected = stall && !redir;
        prev_valid = out_valid;
        prev_out = out;
    endtask

    // Thresholds are out of 16
    task automatic run_phase(input int cycles, input logic [3:0] stall_thr,
                             input logic [3:0] redir_thr);
        logic [31:0] r;
        fetch_pkg::pc_t rpc;
        repeat (cycles) begin
            r = next_random();
            rpc = '0;
            rpc[`IMEM_IDX_W+1:2] = r[`IMEM_IDX_W+15:16];
            drive_cycle(r[3:0] < stall_thr, r[7:4] < redir_thr, rpc);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %-16s %0d errors, %0d accepted so far", name, errors - errors_mark,
                 accepted);
        errors_mark = errors;
    endtask

    initial begin
        rst_n = 1'b0;
        out_stall = 1'b0;
        redirect_en = 1'b0;
        redirect_pc = '0;
        wr_en = 1'b0;
        wr_idx = '0;
        wr_data = '0;
        rng_state = 32'd61;
        exp_pc = `FETCH_RESET_PC;
        hold_expected = 1'b0;
        prev_valid = 1'b0;
        prev_out = '0;
        redirect_pending = 1'b0;
        errors = 0;
        errors_mark = 0;
        checks = 0;
        accepted = 0;
        jal_count = 0;
        redirect_count = 0;
        load_program();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_flag("out_valid in reset", out_valid, 1'b0);
        end
        rst_n = 1'b1;

        // First output must come on the second cycle after release
        first = 0;
        mark = 0;
        while (first == 0 && mark < T1_CYCLES) begin
            mark++;
            drive_cycle(1'b0, 1'b0, '0);
            if (last_accept) begin
                first = mark;
            end
        end
        if (first != 2) begin
            errors++;
            $display("first instruction arrived %0d cycles after reset, expected 2", first);
        end
        check_pc("first out.pc", last_out.pc, `FETCH_RESET_PC);
        check_instr("first out.instr", last_out.instr, mirror[0]);
        report_test("reset state");

        run_phase(T2_CYCLES, 4'd0, 4'd0);
        report_test("sequential");

        mark = jal_count;
        run_phase(T3_CYCLES, 4'd0, 4'd0);
        if (jal_count == mark) begin
            errors++;
            $display("no JAL was delivered during the JAL test");
        end
        report_test("jal redirect");

        mark = accepted;
        run_phase(T4_CYCLES, 4'd6, 4'd0);
        if (accepted == mark) begin
            errors++;
            $display("nothing was accepted during the stall test");
        end
        report_test("random stall");

        mark = redirect_count;
        run_phase(T5_CYCLES, 4'd5, 4'd1);
        if (redirect_count == mark) begin
            errors++;
            $display("no redirect target was delivered during the redirect test");
        end
        report_test("redirect");

        $display("checks %0d, errors %0d, accepted %0d, jal %0d, redirects %0d",
                 checks, errors, accepted, jal_count, redirect_count);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* fetch_frontend.f */
+incdir+.
rv_isa_pkg.sv
fetch_pkg.sv
fetch1_pc_gen.sv
imem_sync_ram.sv
fetch2_predecode.sv
fetch_hazard_ctrl.sv
fetch_frontend_top.sv
tb_fetch_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the fetch front-end testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ns -f fetch_frontend.f \
    --top-module tb_fetch_frontend -o sim_fetch_frontend \
    && ./obj_dir/sim_fetch_frontend > sim.log 2>&1 \
    || echo "build or simulation stopped with an error"

cat sim.log 2>/dev/null

grep -qx '\*\* PASS \*\*' sim.log \
    && echo "result: passed" \
    || { echo "result: failed"; exit 1; }
